// ==== u2_core.f ====
u2_core_pkg.sv
wb_settings_slave.sv
vita_time_keeper.sv
misc_ctrl_regs.sv
u2_core_top.sv
u2_core_properties.sv
tb_u2_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the u2_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_u2_core \
   -f u2_core.f \
   --Mdir obj_dir \
   -o sim_u2_core
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/sim_u2_core
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit "$status"
fi

exit 0

// ==== tb_u2_core.sv ====
`timescale 1ns/1ps

module tb_u2_core;

   import u2_core_pkg::*;

   localparam int unsigned TICKS = 50;
   localparam int N_RAND         = 300;
   localparam int N_LED          = 40;
   localparam int NUM_TXN        = N_RAND + 2 * N_LED + 40;
   localparam int TIMEOUT_CYCLES = NUM_TXN * 10 + 500;
   localparam int ACK_LIMIT      = 16;

   logic dsp_clk, por_rst;
   logic wb_cyc, wb_stb, wb_we;
   logic [7:0] wb_adr;
   word_t wb_wdat, wb_rdat;
   logic [3:0] wb_sel;
   logic wb_ack;
   logic pps, sim_mode, clk_status, serdes_link_up;
   logic [3:0] clock_divider;
   logic clock_ready, ser_enable, ser_prbsen, ser_loopen, ser_rx_en;
   logic [1:0] clk_en, clk_sel;
   logic adc_oe_a, adc_on_a, adc_oe_b, adc_on_b, phy_resetn, pps_int;
   logic [7:0] leds;
   vita_time_t vita_time;

   // Reference model state
   logic [4:0] m_clk;
   logic [3:0] m_serdes, m_adc;
   logic [7:0] m_led_sw, m_led_src;
   logic       m_phy, m_mode, m_armed;
   word_t      m_secs, m_ticks;
   vita_time_t m_load_val, m_pps;
   int         m_load_cycle;

   integer seed;
   int     cycle_cnt = 0;
   int     ack_cycle;
   word_t  rd_data;

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk) cycle_cnt <= cycle_cnt + 1;

   u2_core_top #(.TICKS_PER_SEC(TICKS)) dut_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
      .wb_dat_i(wb_wdat), .wb_sel_i(wb_sel), .wb_ack_o(wb_ack), .wb_dat_o(wb_rdat),
      .pps_i(pps), .sim_mode_i(sim_mode), .clock_divider_i(clock_divider),
      .clk_status_i(clk_status), .serdes_link_up_i(serdes_link_up),
      .clock_ready_o(clock_ready), .clk_en_o(clk_en), .clk_sel_o(clk_sel),
      .ser_enable_o(ser_enable), .ser_prbsen_o(ser_prbsen), .ser_loopen_o(ser_loopen),
      .ser_rx_en_o(ser_rx_en), .adc_oe_a_o(adc_oe_a), .adc_on_a_o(adc_on_a),
      .adc_oe_b_o(adc_oe_b), .adc_on_b_o(adc_on_b), .phy_resetn_o(phy_resetn),
      .leds_o(leds), .vita_time_o(vita_time), .pps_int_o(pps_int)
   );

   bind wb_settings_slave u2_core_properties props_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
      .we_i(wb_we_i), .ack_i(wb_ack_o), .set_stb_i(set_stb_o)
   );

   //////////////////////////////////////////////////////////////////////
   // Model functions

   // One tick per cycle, ticks wrap at TICKS - 1 into the seconds word
   function automatic vita_time_t advance_time(input vita_time_t t, input int n);
      vita_time_t res;
      int         i;
      res = t;
      for (i = 0; i < n; i++) begin
         if (res[31:0] == TICKS - 1) begin
            res[63:32] = res[63:32] + 32'd1;
            res[31:0]  = 32'd0;
         end else begin
            res[31:0] = res[31:0] + 32'd1;
         end
      end
      return res;
   endfunction

   function automatic vita_time_t model_time(input int c);
      return advance_time(m_load_val, c - m_load_cycle);
   endfunction

   function automatic word_t expected_rb(input logic [3:0] idx, input int c);
      vita_time_t t;
      t = model_time(c);
      case (idx)
         4'd9:    return {sim_mode, 27'd0, clock_divider};
         4'd10:   return t[63:32];
         4'd11:   return t[31:0];
         4'd12:   return COMPAT_NUM;
         4'd14:   return m_pps[63:32];
         4'd15:   return m_pps[31:0];
         default: return 32'd0;
      endcase
   endfunction

   function automatic logic [7:0] led_expect();
      logic [7:0] hw;
      logic [7:0] res;
      int         b;
      hw    = 8'h00;
      hw[2] = clk_status;
      hw[1] = serdes_link_up;
      for (b = 0; b < 8; b++) begin
         res[b] = m_led_src[b] ? hw[b] : m_led_sw[b];
      end
      return res;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Checks and bus tasks

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
         $display("Finished with errors");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic check_outputs();
      check_value("clock_ready_o", 64'(clock_ready), 64'(m_clk[4]));
      check_value("clk_en_o", 64'(clk_en), 64'(m_clk[3:2]));
      check_value("clk_sel_o", 64'(clk_sel), 64'(m_clk[1:0]));
      check_value("ser_enable_o", 64'(ser_enable), 64'(m_serdes[3]));
      check_value("ser_prbsen_o", 64'(ser_prbsen), 64'(m_serdes[2]));
      check_value("ser_loopen_o", 64'(ser_loopen), 64'(m_serdes[1]));
      check_value("ser_rx_en_o", 64'(ser_rx_en), 64'(m_serdes[0]));
      check_value("adc_oe_a_o", 64'(adc_oe_a), 64'(m_adc[3]));
      check_value("adc_on_a_o", 64'(adc_on_a), 64'(m_adc[2]));
      check_value("adc_oe_b_o", 64'(adc_oe_b), 64'(m_adc[1]));
      check_value("adc_on_b_o", 64'(adc_on_b), 64'(m_adc[0]));
      check_value("phy_resetn_o", 64'(phy_resetn), 64'(!m_phy));
      check_value("leds_o", 64'(leds), 64'(led_expect()));
   endtask

   // Master holds the request until ack, then drops it on the next edge
   task automatic wb_transfer(input logic we, input logic [7:0] adr, input word_t dat);
      int wait_cnt;
      @(posedge dsp_clk);
      wb_cyc  <= 1'b1;
      wb_stb  <= 1'b1;
      wb_we   <= we;
      wb_adr  <= adr;
      wb_wdat <= dat;
      wb_sel  <= 4'hF;
      wait_cnt = 0;
      do begin
         @(negedge dsp_clk);
         wait_cnt++;
      end while (!wb_ack && wait_cnt < ACK_LIMIT);
      assert (wb_ack) else begin
         $display("No ack from the slave within %0d cycles", ACK_LIMIT);
         $display("Finished with errors");
         $fatal(1, "bus handshake timed out");
      end
      // Request sampled on the first edge, ack visible after the second
      check_value("wb_ack_o delay", 64'(wait_cnt), 64'd2);
      ack_cycle = cycle_cnt;
      rd_data   = wb_rdat;
      @(posedge dsp_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] adr, input word_t dat);
      wb_transfer(1'b1, adr, dat);
      case (adr)
         SR_MISC + 8'd0:   m_clk     = dat[4:0];
         SR_MISC + 8'd1:   m_serdes  = dat[3:0];
         SR_MISC + 8'd2:   m_adc     = dat[3:0];
         SR_MISC + 8'd3:   m_led_sw  = dat[7:0];
         SR_MISC + 8'd4:   m_phy     = dat[0];
         SR_MISC + 8'd6:   m_led_src = dat[7:0];
         SR_TIME64:        m_secs    = dat;
         SR_TIME64 + 8'd1: begin
            m_ticks = dat;
            m_armed = 1'b1;
            // Immediate load lands two edges after the ack cycle
            if (m_mode) begin
               m_load_val   = {m_secs, dat};
               m_load_cycle = ack_cycle + 2;
               m_armed      = 1'b0;
            end
         end
         SR_TIME64 + 8'd2: m_mode    = dat[0];
         default: ;
      endcase
   endtask

   task automatic read_check(input logic [7:0] adr);
      wb_transfer(1'b0, adr, $random(seed));
      // Readback registered on the edge before the ack cycle
      check_value("wb_dat_o", 64'(rd_data), 64'(expected_rb(adr[3:0], ack_cycle - 1)));
   endtask

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge dsp_clk);
      $display("Watchdog expired after %0d cycles, the test did not complete", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $fatal(1, "watchdog timeout");
   end

   //////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      word_t      r;
      logic [7:0] adr;
      int         n;
      int         k;
      int         rise_cycle;
      seed = 32'h160;
      por_rst = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = 8'd0;
      wb_wdat = 32'd0;
      wb_sel = 4'h0;
      pps = 1'b0;
      sim_mode = 1'b0;
      clock_divider = 4'd0;
      clk_status = 1'b1;
      serdes_link_up = 1'b1;
      m_clk = '0;
      m_serdes = '0;
      m_adc = '0;
      m_led_sw = '0;
      m_phy = 1'b0;
      m_led_src = LED_SRC_RESET;
      m_mode = 1'b0;
      m_armed = 1'b0;
      m_secs = '0;
      m_ticks = '0;
      m_load_val = '0;
      m_pps = '0;
      repeat (10) @(posedge dsp_clk);
      por_rst <= 1'b0;
      @(negedge dsp_clk);
      m_load_cycle = cycle_cnt;
      check_outputs();
      check_value("wb_ack_o", 64'(wb_ack), 64'd0);
      check_value("vita_time_o", vita_time, model_time(cycle_cnt));

      // Random writes and reads, time registers kept out of the way
      for (n = 0; n < N_RAND; n++) begin
         r = $random(seed);
         repeat (r[12:11]) @(posedge dsp_clk);
         if (r[9:8] == 2'b00) begin
            @(posedge dsp_clk);
            sim_mode      <= r[13];
            clock_divider <= r[17:14];
            read_check(r[7:0]);
         end else if (r[9:8] == 2'b01) begin
            read_check(r[7:0]);
         end else begin
            adr = r[10] ? {5'd0, r[2:0]} : r[7:0];
            if (adr >= SR_TIME64 && adr <= SR_TIME64 + 8'd2) begin
               adr = adr ^ 8'h80;
            end
            write_reg(adr, $random(seed));
            @(negedge dsp_clk);
            check_outputs();
         end
      end

      // LED mix under random sources
      for (n = 0; n < N_LED; n++) begin
         r = $random(seed);
         @(posedge dsp_clk);
         clk_status     <= r[0];
         serdes_link_up <= r[1];
         write_reg(SR_MISC + 8'd6, $random(seed));
         write_reg(SR_MISC + 8'd3, $random(seed));
         @(negedge dsp_clk);
         check_outputs();
      end

      // Immediate time load, then readback across the tick rollover
      write_reg(SR_TIME64 + 8'd2, 32'd1);
      write_reg(SR_TIME64, $random(seed));
      r = $random(seed);
      write_reg(SR_TIME64 + 8'd1, r % TICKS);
      for (n = 0; n < 8; n++) begin
         r = $random(seed);
         repeat (r[5:0]) @(posedge dsp_clk);
         read_check(n[0] ? {r[11:8], RB_TIME_LO} : {r[11:8], RB_TIME_HI});
         @(negedge dsp_clk);
         check_value("vita_time_o", vita_time, model_time(cycle_cnt));
      end

      // PPS capture, first with a load armed for the edge
      for (k = 0; k < 2; k++) begin
         if (k == 0) begin
            write_reg(SR_TIME64 + 8'd2, 32'd0);
            write_reg(SR_TIME64, $random(seed));
            r = $random(seed);
            write_reg(SR_TIME64 + 8'd1, r % TICKS);
         end
         @(posedge dsp_clk);
         pps <= 1'b1;
         @(negedge dsp_clk);
         rise_cycle = cycle_cnt;
         while (!pps_int && (cycle_cnt - rise_cycle) < 8) @(negedge dsp_clk);
         assert (pps_int) else begin
            $display("No pps_int_o pulse followed the rise of pps_i");
            $display("Finished with errors");
            $fatal(1, "missing PPS pulse");
         end
         // Two synchronizer flops ahead of the edge detector
         check_value("pps_int_o delay", 64'(cycle_cnt - rise_cycle), 64'd2);
         check_value("vita_time_o", vita_time, model_time(cycle_cnt));
         m_pps = model_time(cycle_cnt);
         if (m_armed) begin
            m_load_val   = {m_secs, m_ticks};
            m_load_cycle = cycle_cnt + 1;
            m_armed      = 1'b0;
         end
         @(negedge dsp_clk);
         check_value("pps_int_o", 64'(pps_int), 64'd0);
         check_value("vita_time_o", vita_time, model_time(cycle_cnt));
         @(posedge dsp_clk);
         pps <= 1'b0;
         read_check({4'd0, RB_PPS_HI});
         read_check({4'd0, RB_PPS_LO});
         read_check({4'd0, RB_TIME_LO});
         repeat (20) @(posedge dsp_clk);
      end

      repeat (5) @(posedge dsp_clk);
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== u2_core_properties.sv ====
`timescale 1ns/1ps

module u2_core_properties (
   input logic dsp_clk,
   input logic por_rst,
   input logic cyc_i,
   input logic stb_i,
   input logic we_i,
   input logic ack_i,
   input logic set_stb_i
);

   // Ack is a single-cycle pulse
   ack_one_cycle: assert property (
      @(posedge dsp_clk) disable iff (por_rst) ack_i |=> !ack_i
   ) else $error("wb_ack_o stayed high for more than one cycle");

   // Ack answers a request sampled on the previous edge
   ack_after_req: assert property (
      @(posedge dsp_clk) disable iff (por_rst) ack_i |-> $past(cyc_i && stb_i)
   ) else $error("wb_ack_o rose without a preceding cyc and stb");

   ack_inside_cycle: assert property (
      @(posedge dsp_clk) disable iff (por_rst) ack_i |-> cyc_i
   ) else $error("wb_ack_o high outside a bus cycle");

   set_stb_on_write: assert property (
      @(posedge dsp_clk) disable iff (por_rst) set_stb_i |-> (ack_i && we_i)
   ) else $error("settings strobe without a write ack");

endmodule

// ==== u2_core_top.sv ====
`timescale 1ns/1ps

module u2_core_top #(
   parameter int unsigned TICKS_PER_SEC = 100000000
) (
   input  logic                            dsp_clk,
   input  logic                            por_rst,

   // Wishbone classic slave port
   input  logic                            wb_cyc_i,
   input  logic                            wb_stb_i,
   input  logic                            wb_we_i,
   input  logic [u2_core_pkg::WB_AW-1:0]   wb_adr_i,
   input  u2_core_pkg::word_t              wb_dat_i,
   input  logic [u2_core_pkg::WB_DW/8-1:0] wb_sel_i,
   output logic                            wb_ack_o,
   output u2_core_pkg::word_t              wb_dat_o,

   input  logic                            pps_i,
   input  logic                            sim_mode_i,
   input  logic [3:0]                      clock_divider_i,
   input  logic                            clk_status_i,
   input  logic                            serdes_link_up_i,

   output logic                            clock_ready_o,
   output logic [1:0]                      clk_en_o,
   output logic [1:0]                      clk_sel_o,
   output logic                            ser_enable_o,
   output logic                            ser_prbsen_o,
   output logic                            ser_loopen_o,
   output logic                            ser_rx_en_o,
   output logic                            adc_oe_a_o,
   output logic                            adc_on_a_o,
   output logic                            adc_oe_b_o,
   output logic                            adc_on_b_o,
   output logic                            phy_resetn_o,
   output logic [7:0]                      leds_o,

   output u2_core_pkg::vita_time_t         vita_time_o,
   output logic                            pps_int_o
);

   import u2_core_pkg::*;

   logic       set_stb;
   set_addr_t  set_addr;
   word_t      set_data;
   vita_time_t vita_time_pps;

   //////////////////////////////////////////////////////////////////////
   // Bus slave, settings strobes out and readback in

   wb_settings_slave wb_slave_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .wb_cyc_i        (wb_cyc_i),
      .wb_stb_i        (wb_stb_i),
      .wb_we_i         (wb_we_i),
      .wb_adr_i        (wb_adr_i),
      .wb_dat_i        (wb_dat_i),
      .wb_ack_o        (wb_ack_o),
      .wb_dat_o        (wb_dat_o),
      .set_stb_o       (set_stb),
      .set_addr_o      (set_addr),
      .set_data_o      (set_data),
      .vita_time_i     (vita_time_o),
      .vita_time_pps_i (vita_time_pps),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i)
   );

   vita_time_keeper #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) time_keeper_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_stb_i       (set_stb),
      .set_addr_i      (set_addr),
      .set_data_i      (set_data),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time_o),
      .vita_time_pps_o (vita_time_pps),
      .pps_int_o       (pps_int_o)
   );

   misc_ctrl_regs misc_regs_i (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_stb_i        (set_stb),
      .set_addr_i       (set_addr),
      .set_data_i       (set_data),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_resetn_o     (phy_resetn_o),
      .leds_o           (leds_o)
   );

endmodule

// ==== misc_ctrl_regs.sv ====
`timescale 1ns/1ps

module misc_ctrl_regs (
   input  logic                   dsp_clk,
   input  logic                   por_rst,

   // Settings bus
   input  logic                   set_stb_i,
   input  u2_core_pkg::set_addr_t set_addr_i,
   input  u2_core_pkg::word_t     set_data_i,

   // Hardware LED sources
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,

   // Clock generator control
   output logic                   clock_ready_o,
   output logic [1:0]             clk_en_o,
   output logic [1:0]             clk_sel_o,

   // SERDES control
   output logic                   ser_enable_o,
   output logic                   ser_prbsen_o,
   output logic                   ser_loopen_o,
   output logic                   ser_rx_en_o,

   // ADC control
   output logic                   adc_oe_a_o,
   output logic                   adc_on_a_o,
   output logic                   adc_oe_b_o,
   output logic                   adc_on_b_o,

   output logic                   phy_resetn_o,
   output logic [7:0]             leds_o
);

   import u2_core_pkg::*;

   localparam set_addr_t ADDR_CLK     = SR_MISC + 8'd0;
   localparam set_addr_t ADDR_SERDES  = SR_MISC + 8'd1;
   localparam set_addr_t ADDR_ADC     = SR_MISC + 8'd2;
   localparam set_addr_t ADDR_LED_SW  = SR_MISC + 8'd3;
   localparam set_addr_t ADDR_PHY     = SR_MISC + 8'd4;
   localparam set_addr_t ADDR_LED_SRC = SR_MISC + 8'd6;

   logic [4:0] clk_q;
   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic [7:0] led_sw_q;
   logic       phy_rst_q;
   logic [7:0] led_src_q;
   logic [7:0] led_hw;

   //////////////////////////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_q     <= '0;
         serdes_q  <= '0;
         adc_q     <= '0;
         led_sw_q  <= '0;
         phy_rst_q <= 1'b0;
         led_src_q <= LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            ADDR_CLK:     clk_q     <= set_data_i[4:0];
            ADDR_SERDES:  serdes_q  <= set_data_i[3:0];
            ADDR_ADC:     adc_q     <= set_data_i[3:0];
            ADDR_LED_SW:  led_sw_q  <= set_data_i[7:0];
            ADDR_PHY:     phy_rst_q <= set_data_i[0];
            ADDR_LED_SRC: led_src_q <= set_data_i[7:0];
            // Other addresses belong to other blocks
            default: ;
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_q;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_q;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_q;

   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_rst_q;

   // LED mix, source bit 1 selects hardware
   assign led_hw = {5'b0, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

// ==== vita_time_keeper.sv ====
`timescale 1ns/1ps

module vita_time_keeper #(
   parameter int unsigned TICKS_PER_SEC = 100000000
) (
   input  logic                    dsp_clk,
   input  logic                    por_rst,

   // Settings bus
   input  logic                    set_stb_i,
   input  u2_core_pkg::set_addr_t  set_addr_i,
   input  u2_core_pkg::word_t      set_data_i,

   input  logic                    pps_i,

   output u2_core_pkg::vita_time_t vita_time_o,
   output u2_core_pkg::vita_time_t vita_time_pps_o,
   output logic                    pps_int_o
);

   import u2_core_pkg::*;

   localparam set_addr_t ADDR_SECS  = SR_TIME64;
   localparam set_addr_t ADDR_TICKS = SR_TIME64 + 8'd1;
   localparam set_addr_t ADDR_MODE  = SR_TIME64 + 8'd2;
   localparam word_t     LAST_TICK  = word_t'(TICKS_PER_SEC - 1);

   word_t      secs_load_q;
   word_t      ticks_load_q;
   time_load_e mode_q;
   logic       armed_q;
   logic       ticks_wr;
   logic       do_load;
   logic       pps_meta_q;
   logic       pps_sync_q;
   logic       pps_dly_q;
   logic       pps_edge;
   vita_time_t time_q;
   vita_time_t time_pps_q;

   //////////////////////////////////////////////////////////////////////
   // Load registers

   assign ticks_wr = set_stb_i && (set_addr_i == ADDR_TICKS);

   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && (set_addr_i == ADDR_SECS)) begin
         secs_load_q <= set_data_i;
      end
      if (ticks_wr) begin
         ticks_load_q <= set_data_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         mode_q <= LOAD_AT_PPS;
      end else if (set_stb_i && (set_addr_i == ADDR_MODE)) begin
         mode_q <= time_load_e'(set_data_i[0]);
      end
   end

   // Writing ticks arms the load, a new write wins over the clear
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         armed_q <= 1'b0;
      end else if (ticks_wr) begin
         armed_q <= 1'b1;
      end else if (do_load) begin
         armed_q <= 1'b0;
      end
   end

   // LOAD_NOW takes effect the cycle after the ticks write
   assign do_load = armed_q && ((mode_q == LOAD_NOW) || pps_edge);

   //////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta_q <= 1'b0;
         pps_sync_q <= 1'b0;
         pps_dly_q  <= 1'b0;
      end else begin
         pps_meta_q <= pps_i;
         pps_sync_q <= pps_meta_q;
         pps_dly_q  <= pps_sync_q;
      end
   end

   assign pps_edge  = pps_sync_q && !pps_dly_q;
   assign pps_int_o = pps_edge;

   //////////////////////////////////////////////////////////////////////
   // Seconds:ticks counter

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_q <= '0;
      end else if (do_load) begin
         time_q <= {secs_load_q, ticks_load_q};
      end else if (time_q[31:0] == LAST_TICK) begin
         time_q <= {time_q[63:32] + 32'd1, 32'd0};
      end else begin
         time_q[31:0] <= time_q[31:0] + 32'd1;
      end
   end

   // Capture holds the pre-load time of the edge cycle
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_pps_q <= '0;
      end else if (pps_edge) begin
         time_pps_q <= time_q;
      end
   end

   assign vita_time_o     = time_q;
   assign vita_time_pps_o = time_pps_q;

endmodule

// ==== wb_settings_slave.sv ====
`timescale 1ns/1ps

module wb_settings_slave (
   input  logic                          dsp_clk,
   input  logic                          por_rst,

   // Wishbone classic slave
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   input  logic                          wb_we_i,
   input  logic [u2_core_pkg::WB_AW-1:0] wb_adr_i,
   input  u2_core_pkg::word_t            wb_dat_i,
   output logic                          wb_ack_o,
   output u2_core_pkg::word_t            wb_dat_o,

   // Settings bus
   output logic                          set_stb_o,
   output u2_core_pkg::set_addr_t        set_addr_o,
   output u2_core_pkg::word_t            set_data_o,

   // Readback sources
   input  u2_core_pkg::vita_time_t       vita_time_i,
   input  u2_core_pkg::vita_time_t       vita_time_pps_i,
   input  logic                          sim_mode_i,
   input  logic [3:0]                    clock_divider_i
);

   import u2_core_pkg::*;

   wb_state_e state_q;
   logic      req_accept;
   word_t     rb_word;
   logic      set_stb_q;
   set_addr_t set_addr_q;
   word_t     set_data_q;
   word_t     rd_data_q;

   // A request is taken only from idle, so the master sees one ack per transfer
   assign req_accept = (state_q == WB_IDLE) && wb_cyc_i && wb_stb_i;

   //////////////////////////////////////////////////////////////////////
   // Handshake FSM

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q <= WB_IDLE;
      end else begin
         case (state_q)
            WB_IDLE: begin
               if (wb_cyc_i && wb_stb_i) begin
                  state_q <= WB_ACK;
               end
            end
            WB_ACK: begin
               state_q <= WB_IDLE;
            end
            default: begin
               state_q <= WB_IDLE;
            end
         endcase
      end
   end

   assign wb_ack_o = (state_q == WB_ACK);

   //////////////////////////////////////////////////////////////////////
   // Settings strobe, lines up with the write ack

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_stb_q <= 1'b0;
      end else begin
         set_stb_q <= req_accept && wb_we_i;
      end
   end

   // Byte selects are not looked at, every write is a full word
   always_ff @(posedge dsp_clk) begin
      if (req_accept) begin
         set_addr_q <= wb_adr_i[SET_AW-1:0];
         set_data_q <= wb_dat_i;
      end
   end

   assign set_stb_o  = set_stb_q;
   assign set_addr_o = set_addr_q;
   assign set_data_o = set_data_q;

   //////////////////////////////////////////////////////////////////////
   // Readback mux

   always_comb begin
      case (wb_adr_i[3:0])
         RB_CONFIG:  rb_word = {sim_mode_i, 27'd0, clock_divider_i};
         RB_TIME_HI: rb_word = vita_time_i[63:32];
         RB_TIME_LO: rb_word = vita_time_i[31:0];
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         // Status and irq words are gone
         default:    rb_word = '0;
      endcase
   end

   // Time is sampled on the same edge that raises ack
   always_ff @(posedge dsp_clk) begin
      if (req_accept) begin
         rd_data_q <= rb_word;
      end
   end

   assign wb_dat_o = rd_data_q;

endmodule

// ==== u2_core_pkg.sv ====
package u2_core_pkg;

   // Bus widths
   localparam int WB_DW  = 32;
   localparam int WB_AW  = 8;
   localparam int SET_AW = 8;

   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [WB_DW-1:0]  word_t;
   // Seconds in the upper word, ticks in the lower word
   typedef logic [63:0]       vita_time_t;

   //////////////////////////////////////////////////////////////////////
   // Settings bus map

   // Misc control block, 7 addresses from here
   localparam set_addr_t SR_MISC   = 8'd0;
   // VITA time load, secs / ticks / mode
   localparam set_addr_t SR_TIME64 = 8'd10;

   // LEDs 1 to 4 under hardware control out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;

   //////////////////////////////////////////////////////////////////////
   // Readback space, selected by the low 4 address bits

   localparam logic [3:0] RB_CONFIG  = 4'd9;
   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_PPS_HI  = 4'd14;
   localparam logic [3:0] RB_PPS_LO  = 4'd15;

   // Bump when the register map changes in a way software can see
   localparam word_t COMPAT_NUM = 32'd6;

   typedef enum logic {
      WB_IDLE,
      WB_ACK
   } wb_state_e;

   typedef enum logic {
      LOAD_AT_PPS = 1'b0,
      LOAD_NOW    = 1'b1
   } time_load_e;

endpackage
